// ==== tb.f ====
+incdir+common
common/audio_pkg.sv
fetch/sample_fetcher.sv
fetch/mem_arbiter.sv
source/sample_mixer.sv
source/i2s_transmitter.sv
source/playback_top.sv
verif/ddr_model.sv
verif/playback_tb.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module playback_tb -o Vplayback_tb

run: build
	./obj_dir/Vplayback_tb | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module playback_tb

clean:
	rm -rf obj_dir sim.log

// ==== verif/playback_tb.sv ====
`include "audio_defs.svh"

module playback_tb import audio_pkg::*; ();

	// ############################################################
	// DUT, memory model and clock
	// ############################################################

	localparam int RUN_FRAMES = 134; // One leading silent frame, 128 data frames, a silent tail.
	localparam int ALL_FRAMES = 3 + 4 * (RUN_FRAMES + 2);
	localparam longint LIMIT = longint'(ALL_FRAMES) * 64 * 2 * `BCLK_DIV * 10 * 2;

	logic clock;
	logic reset_l;
	chunk_t mem_data;
	logic mem_ack;
	logic [`MEM_ADDR_W-1:0] mem_addr;
	logic mem_read_en;
	logic [`VOICES-1:0][`BASE_W-1:0] base;
	logic [`VOICES-1:0] base_valid;
	logic [`VOICES-1:0] base_ack;
	logic bclk, lrclk, sdata;

	playback_top uut (.*);

	ddr_model mem (.clock, .reset_l, .mem_addr, .mem_read_en, .mem_data, .mem_ack);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	int errors = 0;      // All failed checks.
	int test_errors = 0; // Failed checks of the running test.
	int tests_run = 0;
	int tests_failed = 0;

	stereo_frame_t frames_q[$];            // Frames captured from I2S.
	logic [`MEM_ADDR_W-1:0] read_log[$];   // Every address read from memory.
	int total_frames = 0;
	logic [`BASE_W-1:0] run_bases [`VOICES];

	// ############################################################
	// Monitors
	// ############################################################

	// Data bits sit in slots 1..63 and slot 0 of the next frame.
	logic [63:0] sreg = '0;
	logic prev_lr = 1'b0;
	always @(posedge bclk) begin
		sreg = {sreg[62:0], sdata};
		if (prev_lr && !lrclk) begin
			frames_q.push_back({sreg[63:48], sreg[31:16]});
			total_frames++;
		end
		prev_lr = lrclk;
	end

	// The bit clock period is 2 * BCLK_DIV system clocks.
	time last_rise = 0;
	bit seen_rise = 1'b0;
	always @(posedge bclk) begin
		if (seen_rise) begin
			assert ($time - last_rise == 2 * `BCLK_DIV * 10) else begin
				$display("CHECK FAILED: bclk period got %h expected %h",
					$time - last_rise, 2 * `BCLK_DIV * 10);
				errors++;
				test_errors++;
			end
		end
		seen_rise = 1'b1;
		last_rise = $time;
	end

	bit outstanding = 1'b0;
	always @(posedge clock) begin
		if (mem_ack)
			outstanding = 1'b0;
		if (mem_read_en) begin
			assert (!outstanding) else begin
				$display("A memory read was issued while another one was outstanding");
				errors++;
				test_errors++;
			end
			outstanding = 1'b1;
			read_log.push_back(mem_addr);
		end
	end

	initial begin
		#(LIMIT);
		$display("Watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ############################################################
	// Expected values
	// ############################################################

	function automatic chunk_t expected_word(input logic [`MEM_ADDR_W-1:0] addr, input bit loud);
		chunk_t w;
		logic signed [15:0] v;
		for (int i = 0; i < 4; i++) begin
			if (loud) begin
				v = 16'sh6000 + $signed({8'h00, addr[7:0]});
				w.raw[16*i +: 16] = (i % 2 == 1) ? v : -v;
			end else begin
				w.raw[16*i +: 16] = 16'(addr[9:0]) * 16'd4 + 16'(i) + 16'd1;
			end
		end
		return w;
	endfunction

	function automatic int clamp16(input int x);
		if (x > 32767)
			return 32767;
		if (x < -32768)
			return -32768;
		return x;
	endfunction

	// Frame k of a run is frame k%2 of chunk k/2 of each voice's block, summed.
	function automatic stereo_frame_t expected_mix(input logic [`VOICES-1:0] mask, input int k,
			input bit loud);
		chunk_t w;
		stereo_frame_t f;
		int l;
		int r;
		l = 0;
		r = 0;
		for (int v = 0; v < `VOICES; v++) begin
			if (mask[v]) begin
				w = expected_word({run_bases[v], 6'(k / 2)}, loud);
				f = w.frames[k % 2];
				l += int'(f.left);
				r += int'(f.right);
			end
		end
		f.left = 16'(clamp16(l));
		f.right = 16'(clamp16(r));
		return f;
	endfunction

	// ############################################################
	// Test helpers
	// ############################################################

	task automatic check_frame(input int idx, input stereo_frame_t exp);
		assert (frames_q[idx] == exp) else begin
			$display("CHECK FAILED: frame[%0d] got %h expected %h", idx, frames_q[idx], exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed", test_errors);
		test_errors = 0;
	endtask

	// Hand each masked voice its base and hold base_valid until base_ack is seen.
	task automatic give_bases(input logic [`VOICES-1:0] mask);
		logic [`VOICES-1:0] left_to_ack;
		int cycles;
		left_to_ack = mask;
		cycles = 0;
		for (int v = 0; v < `VOICES; v++)
			if (mask[v])
				base[v] <= run_bases[v];
		base_valid <= mask;
		while (left_to_ack != '0 && cycles < 100) begin
			@(posedge clock);
			cycles++;
			for (int v = 0; v < `VOICES; v++) begin
				if (left_to_ack[v] && base_ack[v]) begin
					left_to_ack[v] = 1'b0;
					base_valid[v] <= 1'b0;
				end
			end
		end
		assert (left_to_ack == '0) else begin
			$display("base_ack never rose for voices %b", left_to_ack);
			errors++;
			test_errors++;
			base_valid <= '0;
		end
	endtask

	// Plays one block on each masked voice and checks frames and reads.
	task automatic run_block(input string name, input logic [`VOICES-1:0] mask,
			input bit loud, input bit random_delay);
		int n;
		int hits;
		int voices;
		mem.loud = loud;
		mem.random_delay = random_delay;
		mem.delay = 1 + int'($urandom % 6);
		n = total_frames;
		wait (total_frames != n); // Start right after a frame boundary.
		frames_q.delete();
		read_log.delete();
		give_bases(mask);
		while (frames_q.size() < RUN_FRAMES)
			@(posedge bclk);
		check_frame(0, '0);
		for (int k = 0; k < 128; k++)
			check_frame(k + 1, expected_mix(mask, k, loud));
		for (int i = 129; i < RUN_FRAMES; i++)
			check_frame(i, '0);
		voices = 0;
		for (int v = 0; v < `VOICES; v++) begin
			if (mask[v]) begin
				voices++;
				for (int c = 0; c < 64; c++) begin
					hits = 0;
					foreach (read_log[i])
						if (read_log[i] == {run_bases[v], 6'(c)})
							hits++;
					assert (hits == 1) else begin
						$display("Voice %0d chunk %0d was read %0d times", v, c, hits);
						errors++;
						test_errors++;
					end
				end
			end
		end
		assert (read_log.size() == 64 * voices) else begin
			$display("CHECK FAILED: read count got %h expected %h", read_log.size(), 64 * voices);
			errors++;
			test_errors++;
		end
		finish_test(name);
	endtask

	// ############################################################
	// Tests
	// ############################################################

	task automatic idle_after_reset();
		wait (total_frames >= 3);
		for (int i = 0; i < 3; i++)
			check_frame(i, '0);
		assert (read_log.size() == 0) else begin
			$display("Memory was read before any base was given");
			errors++;
			test_errors++;
		end
		finish_test("idle_after_reset");
	endtask

	initial begin
		void'($urandom(32'hb83ffe8e));
		reset_l = 1'b0;
		base = '0;
		base_valid = '0;
		repeat (4) @(posedge clock);
		reset_l <= 1'b1;

		idle_after_reset();

		run_bases[0] = 23'h000123;
		run_block("single_voice", 4'b0001, 1'b0, 1'b0);

		run_bases[0] = 23'h0004a7; // Second base after the block ran out.
		run_block("end_of_block", 4'b0001, 1'b0, 1'b0);

		for (int v = 0; v < `VOICES; v++)
			run_bases[v] = 23'h010000 + 23'(v * 9);
		run_block("four_voice_saturate", 4'b1111, 1'b1, 1'b0);

		for (int v = 0; v < `VOICES; v++)
			run_bases[v] = 23'h020040 + 23'(v * 5);
		run_block("random_delay", 4'b1111, 1'b0, 1'b1);

		$display("Tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule : playback_tb

// ==== verif/ddr_model.sv ====
`include "audio_defs.svh"

module ddr_model import audio_pkg::*; (
	input  logic                   clock,
	input  logic                   reset_l,
	input  logic [`MEM_ADDR_W-1:0] mem_addr,
	input  logic                   mem_read_en,
	output chunk_t                 mem_data,
	output logic                   mem_ack
);

	int delay = 1;          // Cycles from a read to its ack, set by the tests.
	bit random_delay = 1'b0; // When set, every read draws its own delay.
	bit loud = 1'b0;         // Near full scale data to drive the mixer into saturation.

	logic [`MEM_ADDR_W-1:0] addr_q;
	int                     wait_cnt;

	// Data is a pure function of the address, one small signed value per 16-bit lane.
	function automatic chunk_t data_at(input logic [`MEM_ADDR_W-1:0] addr);
		chunk_t w;
		logic [15:0] mag;
		mag = 16'h6000 | {8'h00, addr[7:0]};
		for (int i = 0; i < 4; i++) begin
			if (loud)
				w.raw[16*i +: 16] = i[0] ? mag : -mag; // Left lanes high, right lanes low.
			else
				w.raw[16*i +: 16] = {4'h0, addr[9:0], i[1:0]} + 16'd1;
		end
		return w;
	endfunction

	always @(posedge clock or negedge reset_l) begin
		if (!reset_l) begin
			mem_ack <= 1'b0;
			mem_data <= '0;
			wait_cnt <= 0;
		end else begin
			mem_ack <= 1'b0;
			if (mem_read_en) begin
				addr_q <= mem_addr;
				wait_cnt <= random_delay ? 1 + int'($urandom % 6) : delay;
			end else if (wait_cnt != 0) begin
				wait_cnt <= wait_cnt - 1;
				if (wait_cnt == 1) begin
					mem_ack <= 1'b1; // One-cycle ack with the word.
					mem_data <= data_at(addr_q);
				end
			end
		end
	end

endmodule : ddr_model

// ==== source/playback_top.sv ====
`include "audio_defs.svh"

module playback_top import audio_pkg::*; (
	input  logic                             clock,
	input  logic                             reset_l,

	// Shared DDR3 read port.
	input  chunk_t                           mem_data,
	input  logic                             mem_ack,
	output logic [`MEM_ADDR_W-1:0]           mem_addr,
	output logic                             mem_read_en,

	// Per-voice block bases.
	input  logic [`VOICES-1:0][`BASE_W-1:0]  base,
	input  logic [`VOICES-1:0]               base_valid,
	output logic [`VOICES-1:0]               base_ack,

	// I2S output.
	output logic                             bclk,
	output logic                             lrclk,
	output logic                             sdata
);

	// ############################################################
	// Internal wiring
	// ############################################################

	logic [`VOICES-1:0]                  voice_read_en;
	logic [`VOICES-1:0][`MEM_ADDR_W-1:0] voice_addr;
	logic [`VOICES-1:0]                  voice_ack;

	chunk_t [`VOICES-1:0]                chunk;
	logic   [`VOICES-1:0]                chunk_valid;
	logic   [`VOICES-1:0]                chunk_ack;

	logic          frame_req;
	stereo_frame_t frame;

	mem_arbiter arbiter (
		.clock, .reset_l,
		.voice_read_en, .voice_addr, .voice_ack,
		.mem_addr, .mem_read_en, .mem_ack
	);

	// One fetcher per voice. Read data is broadcast, and each voice keeps
	// it only on its own ack.
	for (genvar v = 0; v < `VOICES; v++) begin : g_voice
		sample_fetcher fetcher (
			.clock, .reset_l,
			.voice_ack     (voice_ack[v]),
			.mem_data      (mem_data),
			.voice_addr    (voice_addr[v]),
			.voice_read_en (voice_read_en[v]),
			.chunk         (chunk[v]),
			.chunk_valid   (chunk_valid[v]),
			.chunk_ack     (chunk_ack[v]),
			.base          (base[v]),
			.base_valid    (base_valid[v]),
			.base_ack      (base_ack[v])
		);
	end

	sample_mixer mixer (
		.clock, .reset_l,
		.chunk, .chunk_valid, .chunk_ack,
		.frame_req,
		.frame_out (frame)
	);

	i2s_transmitter transmitter (
		.clock, .reset_l,
		.frame_in (frame),
		.frame_req,
		.bclk, .lrclk, .sdata
	);

endmodule : playback_top

// ==== source/i2s_transmitter.sv ====
`include "audio_defs.svh"

module i2s_transmitter import audio_pkg::*; (
	input  logic          clock,
	input  logic          reset_l,

	input  stereo_frame_t frame_in,  // Mixed frame, valid after frame_req.
	output logic          frame_req, // Pulses once per word-clock period.

	output logic          bclk,
	output logic          lrclk,
	output logic          sdata
);

	localparam int DIV_W = ($clog2(`BCLK_DIV) > 0) ? $clog2(`BCLK_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;  // Clocks within the current bclk half period.
	logic [5:0]       bit_cnt;  // Bit slot within the 64-slot frame.
	logic [5:0]       next_bit; // Slot that starts on the next falling bclk edge.
	logic [63:0]      shift;    // Bits still to go out, MSB first.

	assign next_bit = bit_cnt + 1'b1; // Wraps from 63 back to slot 0.

	// ############################################################
	// Bit clock, word clock and data shifter
	// ############################################################

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			div_cnt <= '0;
			bit_cnt <= '0;
			bclk <= 1'b0;
			lrclk <= 1'b0;
			sdata <= 1'b0;
			frame_req <= 1'b0;
			shift <= '0; // The first frame is silent.
		end else begin
			frame_req <= 1'b0;
			if (div_cnt == DIV_W'(`BCLK_DIV - 1)) begin
				div_cnt <= '0;
				bclk <= ~bclk;
				// Everything changes on the falling edge so the receiver
				// samples stable data on the rising edge.
				if (bclk) begin
					bit_cnt <= next_bit;
					lrclk <= next_bit[5];  // Low for left, high for right.
					sdata <= shift[63];    // Lags the word clock by one bit.
					if (next_bit == '0)
						// Each channel gets 32 slots, sample bits first.
						shift <= {frame_in.left, 16'd0, frame_in.right, 16'd0};
					else
						shift <= {shift[62:0], 1'b0};
					if (next_bit == 6'd63)
						frame_req <= 1'b1; // Last slot, ask for the next frame.
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule : i2s_transmitter

// ==== source/sample_mixer.sv ====
`include "audio_defs.svh"

module sample_mixer import audio_pkg::*; (
	input  logic                     clock,
	input  logic                     reset_l,

	// Held chunks from every fetcher.
	input  chunk_t [`VOICES-1:0]     chunk,
	input  logic   [`VOICES-1:0]     chunk_valid,
	output logic   [`VOICES-1:0]     chunk_ack,

	// Frame hand-off to the I2S transmitter.
	input  logic                     frame_req,
	output stereo_frame_t            frame_out
);

	// Enough headroom that the sum of all voices never wraps.
	localparam int ACC_W = 16 + $clog2(`VOICES) + 1;

	localparam logic signed [ACC_W-1:0] SAT_MAX = 32767;
	localparam logic signed [ACC_W-1:0] SAT_MIN = -32768;

	logic [`VOICES-1:0] half; // Which frame of each chunk plays next.

	logic signed [ACC_W-1:0] sum_left;
	logic signed [ACC_W-1:0] sum_right;

	// Clamp the wide sum back into the 16-bit signed sample range.
	function automatic logic signed [15:0] saturate(input logic signed [ACC_W-1:0] value);
		if (value > SAT_MAX)
			return 16'sh7fff;
		else if (value < SAT_MIN)
			return 16'sh8000;
		else
			return value[15:0];
	endfunction

	// ############################################################
	// Voice sum
	// ############################################################

	always_comb begin
		stereo_frame_t sel;
		sum_left = '0;
		sum_right = '0;
		for (int v = 0; v < `VOICES; v++) begin
			sel = chunk[v].frames[half[v]]; // Frame view of the held word.
			// A voice with no chunk is silent this frame.
			if (chunk_valid[v]) begin
				sum_left = sum_left + ACC_W'(sel.left);
				sum_right = sum_right + ACC_W'(sel.right);
			end
		end
	end

	// ############################################################
	// Frame output and chunk release
	// ############################################################

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			half <= '0;
			chunk_ack <= '0;
			frame_out <= '0; // Silence until the first request.
		end else begin
			chunk_ack <= '0;
			if (frame_req) begin
				frame_out.left <= saturate(sum_left);
				frame_out.right <= saturate(sum_right);
				for (int v = 0; v < `VOICES; v++) begin
					// Voices without data keep their place in the chunk.
					if (chunk_valid[v]) begin
						half[v] <= ~half[v];
						chunk_ack[v] <= half[v]; // Frame 1 was just played.
					end
				end
			end
		end
	end

	// The fetcher still holds its chunk while it is being acknowledged.
	a_ack_only_valid: assert property (@(posedge clock) disable iff (!reset_l)
		(chunk_ack & ~chunk_valid) == '0);

endmodule : sample_mixer

// ==== fetch/mem_arbiter.sv ====
`include "audio_defs.svh"

module mem_arbiter (
	input  logic                                 clock,
	input  logic                                 reset_l,

	// Per-voice requests from the fetchers.
	input  logic [`VOICES-1:0]                   voice_read_en,
	input  logic [`VOICES-1:0][`MEM_ADDR_W-1:0]  voice_addr,
	output logic [`VOICES-1:0]                   voice_ack,

	// Single shared DDR3 read port.
	output logic [`MEM_ADDR_W-1:0]               mem_addr,
	output logic                                 mem_read_en,
	input  logic                                 mem_ack
);

	localparam int IDX_W = (`VOICES > 1) ? $clog2(`VOICES) : 1;

	logic [`VOICES-1:0]                  pending;    // One queued read per voice.
	logic [`VOICES-1:0][`MEM_ADDR_W-1:0] slot_addr;  // Address latched with each request.
	logic                                busy;       // A read is outstanding on memory.
	logic [IDX_W-1:0]                    owner;      // Voice that owns the outstanding read.
	logic [IDX_W-1:0]                    last_grant; // Round-robin pointer.

	logic             grant_found;
	logic [IDX_W-1:0] grant_idx;
	logic             issue; // Forward a read to memory this cycle.

	// ############################################################
	// Round-robin pick
	// ############################################################

	// Search starts at the voice after the last one granted and wraps around.
	always_comb begin
		int cand;
		grant_found = 1'b0;
		grant_idx = last_grant;
		for (int i = 1; i <= `VOICES; i++) begin
			cand = (int'(last_grant) + i) % `VOICES;
			if (!grant_found && pending[cand]) begin
				grant_found = 1'b1;
				grant_idx = IDX_W'(cand);
			end
		end
		issue = !busy && grant_found; // Memory takes one read at a time.
	end

	// ############################################################
	// Control registers
	// ############################################################

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			pending <= '0;
			busy <= 1'b0;
			owner <= '0;
			last_grant <= IDX_W'(`VOICES - 1); // So voice 0 is looked at first.
			mem_read_en <= 1'b0;
			voice_ack <= '0;
		end else begin
			mem_read_en <= 1'b0;
			voice_ack <= '0;

			if (issue) begin
				pending[grant_idx] <= 1'b0;
				busy <= 1'b1;
				owner <= grant_idx;
				last_grant <= grant_idx;
				mem_read_en <= 1'b1; // One-cycle read strobe.
			end else if (busy && mem_ack) begin
				busy <= 1'b0;
				voice_ack[owner] <= 1'b1; // Only the owner sees the ack.
			end

			// New requests are queued after the grant so they are never lost.
			for (int v = 0; v < `VOICES; v++)
				if (voice_read_en[v])
					pending[v] <= 1'b1;
		end
	end

	// Each voice's request address, and the one sent out with a grant.
	always_ff @(posedge clock) begin
		for (int v = 0; v < `VOICES; v++)
			if (voice_read_en[v])
				slot_addr[v] <= voice_addr[v];
		if (issue)
			mem_addr <= slot_addr[grant_idx];
	end

	// Memory only acknowledges the read that is outstanding.
	a_ack_when_busy: assert property (@(posedge clock) disable iff (!reset_l)
		mem_ack |-> busy);

	// A voice waits for its ack before it asks again.
	a_no_double_request: assert property (@(posedge clock) disable iff (!reset_l)
		(voice_read_en & pending) == '0);

endmodule : mem_arbiter

// ==== fetch/sample_fetcher.sv ====
`include "audio_defs.svh"

module sample_fetcher import audio_pkg::*; (
	input  logic                      clock,
	input  logic                      reset_l,

	// Shared memory read path through the arbiter.
	input  logic                      voice_ack,
	input  chunk_t                    mem_data,
	output logic [`MEM_ADDR_W-1:0]    voice_addr,
	output logic                      voice_read_en,

	// Held chunk for the mixer.
	output chunk_t                    chunk,
	output logic                      chunk_valid,
	input  logic                      chunk_ack,

	// Block base hand-off from the outside.
	input  logic [`BASE_W-1:0]        base,
	input  logic                      base_valid,
	output logic                      base_ack
);

	// ############################################################
	// State
	// ############################################################

	typedef enum logic {
		IDLE,      // Free to issue a read.
		READ_WAIT  // One read outstanding, waiting for voice_ack.
	} fetch_state_t;

	fetch_state_t state;

	logic [`BASE_W-1:0]            addr;       // Base of the block being played.
	logic                          addr_valid; // Block still has chunks left to read.
	logic [`BLOCK_CHUNKS_LOG2-1:0] chunk_addr; // Next chunk within the block.

	logic last_chunk; // The next read is the final chunk of the block.
	logic block_done; // The final chunk is being requested this cycle.

	// ############################################################
	// Request and base hand-off
	// ############################################################

	always_comb begin
		last_chunk = (chunk_addr == '1);

		// Only read when nothing is held, nothing is in flight and the block is live.
		voice_read_en = (state == IDLE) && !chunk_valid && addr_valid;
		block_done = voice_read_en && last_chunk;

		// A new base is taken once the old block has issued its last read.
		// It may also be taken in the very cycle that the last read goes out.
		base_ack = base_valid && (!addr_valid || block_done);

		voice_addr = {addr, chunk_addr}; // Chunk address within the whole memory.
	end

	// ############################################################
	// Control registers
	// ############################################################

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			state <= IDLE;
			addr_valid <= 1'b0;
			chunk_addr <= '0;
			chunk_valid <= 1'b0;
		end else begin
			// The counter wraps to zero after chunk 63, ready for the next base.
			if (voice_read_en)
				chunk_addr <= chunk_addr + 1'b1;

			// A newly accepted base wins over the end of the old block.
			if (base_ack)
				addr_valid <= 1'b1;
			else if (block_done)
				addr_valid <= 1'b0;

			if (voice_ack)
				chunk_valid <= 1'b1; // Data lands with the ack.
			else if (chunk_ack)
				chunk_valid <= 1'b0; // Mixer has played both frames.

			unique case (state)
				IDLE:      if (voice_read_en) state <= READ_WAIT;
				READ_WAIT: if (voice_ack) state <= IDLE;
			endcase
		end
	end

	// Block base on accept, memory word on this voice's own ack.
	always_ff @(posedge clock) begin
		if (base_ack)
			addr <= base;
		if (voice_ack)
			chunk <= mem_data;
	end

	// The arbiter only answers a read that this voice has in flight.
	a_ack_in_wait: assert property (@(posedge clock) disable iff (!reset_l)
		voice_ack |-> (state == READ_WAIT));

endmodule : sample_fetcher

// ==== common/audio_pkg.sv ====
package audio_pkg;

	// ############################################################
	// Sample and chunk types
	// ############################################################

	// One stereo sample pair as it is played out.
	// Left sits in the upper half of the 32-bit word.
	typedef struct packed {
		logic signed [15:0] left;  // Left channel, two's complement.
		logic signed [15:0] right; // Right channel, two's complement.
	} stereo_frame_t;

	// A 64-bit memory word holds two stereo frames.
	// The memory side only sees the raw word, while the mixer picks it apart
	// into frames. Frame 0 is in the low 32 bits and is played first.
	typedef union packed {
		logic [63:0]              raw;    // Word exactly as read from DDR3.
		stereo_frame_t [1:0]      frames; // Two frames, index 0 played first.
	} chunk_t;

endpackage : audio_pkg

// ==== common/audio_defs.svh ====
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

// Number of voice fetchers. The arbiter and the mixer scale with it (1 to 8).
`define VOICES 4

// Each block is 2**6 = 64 chunks of 8 bytes, so 512 bytes per block.
`define BLOCK_CHUNKS_LOG2 6

// Block base address width, in units of whole blocks.
`define BASE_W 23

// Full chunk address on the memory port: 23 + 6 = 29 bits.
`define MEM_ADDR_W (`BASE_W + `BLOCK_CHUNKS_LOG2)

// System clocks per half period of the I2S bit clock.
`define BCLK_DIV 4

`endif
